/* design/commit_if.sv */
`timescale 1ns/1ps

// Restart pulse and four in-order commit candidates where cand3 is the youngest.
interface commit_if;
	logic restart;
	logic [3:0] cand_valid;
	rename_pkg::lreg_t cand_lreg [4];
	rename_pkg::preg_t cand_preg [4];

	modport sink (
		input restart,
		input cand_valid,
		input cand_lreg,
		input cand_preg
	);

endinterface

/* design/free_list.sv */
`timescale 1ns/1ps
`include "rename_params.svh"

module free_list (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic stall,
	rename_if.alloc rename,
	commit_if.sink commit,
	input  logic release_valid0,
	input  logic release_valid1,
	input  rename_pkg::preg_t release_preg0,
	input  rename_pkg::preg_t release_preg1
);
	localparam int idx_w = $clog2(`RENAME_FREE_DEPTH);

	rename_pkg::preg_t slots [`RENAME_FREE_DEPTH];
	rename_pkg::entry_state_t state;
	rename_pkg::fptr_t spec_head;
	rename_pkg::fptr_t commit_head;
	rename_pkg::fptr_t tail;
	rename_pkg::fptr_t head_next;
	rename_pkg::fptr_t tail_next;
	rename_pkg::fptr_t free_count;
	rename_pkg::fptr_t alloc_cnt;
	rename_pkg::fptr_t commit_cnt;
	rename_pkg::fptr_t release_cnt;

	assign head_next = spec_head + rename_pkg::fptr_t'(1);
	assign tail_next = tail + rename_pkg::fptr_t'(release_valid0);
	assign free_count = tail - spec_head;

	assign rename.lock = stall || commit.restart || (state == rename_pkg::ENTRY_INIT) ||
		(free_count < rename_pkg::fptr_t'(2));

	// A lone valid1 takes the head slot.
	assign rename.preg0 = slots[spec_head[idx_w-1:0]];
	assign rename.preg1 = rename.valid0 ? slots[head_next[idx_w-1:0]] :
		slots[spec_head[idx_w-1:0]];

	assign alloc_cnt = rename_pkg::fptr_t'(rename.valid0) + rename_pkg::fptr_t'(rename.valid1);
	assign release_cnt = rename_pkg::fptr_t'(release_valid0) + rename_pkg::fptr_t'(release_valid1);

	always_comb begin
		commit_cnt = '0;
		for (int i = 0; i < 4; i++) begin
			commit_cnt = commit_cnt + rename_pkg::fptr_t'(commit.cand_valid[i]);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= rename_pkg::ENTRY_INIT;
			spec_head <= '0;
			commit_head <= '0;
			tail <= rename_pkg::fptr_t'(`RENAME_FREE_DEPTH);	// Full list.
		end else begin
			state <= rename_pkg::ENTRY_RUN;
			if (commit.restart) begin
				spec_head <= commit_head;	// Rewind to the committed point.
			end else if (!rename.lock) begin
				spec_head <= spec_head + alloc_cnt;
			end
			commit_head <= commit_head + commit_cnt;
			tail <= tail + release_cnt;
		end
	end

	// Slot storage.
	always_ff @(posedge iCLOCK) begin
		if (state == rename_pkg::ENTRY_INIT) begin
			for (int k = 0; k < `RENAME_FREE_DEPTH; k++) begin
				slots[k] <= rename_pkg::preg_t'(`RENAME_LREGS + k);
			end
		end else begin
			if (release_valid0) begin
				slots[tail[idx_w-1:0]] <= release_preg0;
			end
			if (release_valid1) begin
				slots[tail_next[idx_w-1:0]] <= release_preg1;
			end
		end
	end

	a_free_count_max: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		free_count <= rename_pkg::fptr_t'(`RENAME_FREE_DEPTH));

	// Retire may not commit names that rename has not handed out.
	a_commit_behind_spec: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rename_pkg::fptr_t'(spec_head - commit_head) <= rename_pkg::fptr_t'(`RENAME_FREE_DEPTH));

endmodule

/* design/register_renaming_table.sv */
`timescale 1ns/1ps

module register_renaming_table #(
	parameter int ENTRY_ID = 0
) (
	input  logic iCLOCK,
	input  logic inRESET,
	rename_if.map rename,
	commit_if.sink commit,
	output rename_pkg::preg_t cur_preg
);
	localparam rename_pkg::lreg_t entry_lreg = rename_pkg::lreg_t'(ENTRY_ID);
	localparam rename_pkg::preg_t entry_preg = rename_pkg::preg_t'(ENTRY_ID);

	rename_pkg::entry_state_t state;
	rename_pkg::preg_t spec_preg;
	rename_pkg::preg_t rollback_preg;
	logic commit_hit;
	rename_pkg::preg_t commit_preg;

	// Later candidates are younger and override older ones.
	always_comb begin
		commit_hit = 1'b0;
		commit_preg = rollback_preg;
		for (int i = 0; i < 4; i++) begin
			if (commit.cand_valid[i] && commit.cand_lreg[i] == entry_lreg) begin
				commit_hit = 1'b1;
				commit_preg = commit.cand_preg[i];
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= rename_pkg::ENTRY_INIT;
		end else begin
			state <= rename_pkg::ENTRY_RUN;	// One init cycle after reset.
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (state == rename_pkg::ENTRY_INIT) begin
			spec_preg <= entry_preg;	// Identity mapping.
			rollback_preg <= entry_preg;
		end else begin
			if (commit.restart) begin
				spec_preg <= rollback_preg;
			end else if (!rename.lock) begin
				if (rename.valid1 && rename.ldest1 == entry_lreg) begin
					spec_preg <= rename.preg1;	// Slot 1 wins on equal destinations.
				end else if (rename.valid0 && rename.ldest0 == entry_lreg) begin
					spec_preg <= rename.preg0;
				end
			end
			if (commit_hit) begin
				rollback_preg <= commit_preg;
			end
		end
	end

	assign cur_preg = spec_preg;

	// Lock comes from the free list and must cover every restart.
	a_no_rename_on_restart: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(commit.restart && !rename.lock && (rename.valid0 || rename.valid1)));

endmodule

/* design/rename_if.sv */
`timescale 1ns/1ps

// Rename group between the free list and the map.
interface rename_if;
	logic valid0;
	rename_pkg::lreg_t ldest0;
	logic valid1;
	rename_pkg::lreg_t ldest1;
	rename_pkg::preg_t preg0;
	rename_pkg::preg_t preg1;
	logic lock;

	modport alloc (
		input valid0, valid1,
		output preg0, preg1, lock
	);

	modport map (
		input valid0, ldest0, valid1, ldest1,
		input preg0, preg1, lock
	);

	modport source (
		output valid0, ldest0, valid1, ldest1
	);

endinterface

/* design/rename_map.sv */
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_map (
	input  logic iCLOCK,
	input  logic inRESET,
	rename_if.map rename,
	commit_if.sink commit,
	input  rename_pkg::lreg_t src0,
	input  rename_pkg::lreg_t src1,
	output rename_pkg::preg_t src_preg0,
	output rename_pkg::preg_t src_preg1,
	output rename_pkg::preg_t old0,
	output rename_pkg::preg_t old1
);
	rename_pkg::preg_t entry_preg [`RENAME_LREGS];
	logic src1_hit0;
	logic dest_same;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Map entries, one per logical register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar n = 0; n < `RENAME_LREGS; n++) begin : g_entry
		register_renaming_table #(
			.ENTRY_ID (n)
		) u_entry (
			.iCLOCK   (iCLOCK),
			.inRESET  (inRESET),
			.rename   (rename),
			.commit   (commit),
			.cur_preg (entry_preg[n])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup with in-group bypass
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign src1_hit0 = rename.valid0 && (rename.ldest0 == src1);	// Reads the older result.
	assign dest_same = rename.valid0 && rename.valid1 && (rename.ldest0 == rename.ldest1);

	assign src_preg0 = entry_preg[src0];
	assign src_preg1 = src1_hit0 ? rename.preg0 : entry_preg[src1];

	// Displaced names from the map before this group lands.
	assign old0 = entry_preg[rename.ldest0];
	assign old1 = dest_same ? rename.preg0 : entry_preg[rename.ldest1];

endmodule

/* design/rename_pkg.sv */
`include "rename_params.svh"

package rename_pkg;

	typedef logic [`RENAME_LREG_W-1:0] lreg_t;	// Logical register name.
	typedef logic [`RENAME_PREG_W-1:0] preg_t;	// Physical register name.
	typedef logic [$clog2(`RENAME_FREE_DEPTH):0] fptr_t;	// Slot index plus wrap bit.

	typedef enum logic {
		ENTRY_INIT,
		ENTRY_RUN
	} entry_state_t;

endpackage

/* design/rename_stage_top.sv */
`timescale 1ns/1ps

module rename_stage_top (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic stall,
	input  logic valid0,
	input  rename_pkg::lreg_t ldest0,
	input  logic valid1,
	input  rename_pkg::lreg_t ldest1,
	input  rename_pkg::lreg_t src0,
	input  rename_pkg::lreg_t src1,
	output rename_pkg::preg_t preg0,
	output rename_pkg::preg_t preg1,
	output rename_pkg::preg_t old0,
	output rename_pkg::preg_t old1,
	output rename_pkg::preg_t src_preg0,
	output rename_pkg::preg_t src_preg1,
	output logic rename_lock,
	input  logic restart,
	input  logic cand0_valid,
	input  rename_pkg::lreg_t cand0_lreg,
	input  rename_pkg::preg_t cand0_preg,
	input  logic cand1_valid,
	input  rename_pkg::lreg_t cand1_lreg,
	input  rename_pkg::preg_t cand1_preg,
	input  logic cand2_valid,
	input  rename_pkg::lreg_t cand2_lreg,
	input  rename_pkg::preg_t cand2_preg,
	input  logic cand3_valid,
	input  rename_pkg::lreg_t cand3_lreg,
	input  rename_pkg::preg_t cand3_preg,
	input  logic release_valid0,
	input  logic release_valid1,
	input  rename_pkg::preg_t release_preg0,
	input  rename_pkg::preg_t release_preg1
);
	rename_if rn ();
	commit_if cm ();

	assign rn.valid0 = valid0;
	assign rn.ldest0 = ldest0;
	assign rn.valid1 = valid1;
	assign rn.ldest1 = ldest1;
	assign preg0 = rn.preg0;
	assign preg1 = rn.preg1;
	assign rename_lock = rn.lock;

	assign cm.restart = restart;
	assign cm.cand_valid = {cand3_valid, cand2_valid, cand1_valid, cand0_valid};
	assign cm.cand_lreg[0] = cand0_lreg;
	assign cm.cand_lreg[1] = cand1_lreg;
	assign cm.cand_lreg[2] = cand2_lreg;
	assign cm.cand_lreg[3] = cand3_lreg;	// Youngest.
	assign cm.cand_preg[0] = cand0_preg;
	assign cm.cand_preg[1] = cand1_preg;
	assign cm.cand_preg[2] = cand2_preg;
	assign cm.cand_preg[3] = cand3_preg;

	rename_map u_map (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.rename    (rn.map),
		.commit    (cm.sink),
		.src0      (src0),
		.src1      (src1),
		.src_preg0 (src_preg0),
		.src_preg1 (src_preg1),
		.old0      (old0),
		.old1      (old1)
	);

	free_list u_free (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.stall          (stall),
		.rename         (rn.alloc),
		.commit         (cm.sink),
		.release_valid0 (release_valid0),
		.release_valid1 (release_valid1),
		.release_preg0  (release_preg0),
		.release_preg1  (release_preg1)
	);

endmodule

/* include/rename_params.svh */
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Register file sizes.
`define RENAME_LREGS 32
`define RENAME_PREGS 64

// Name widths.
`define RENAME_LREG_W 5
`define RENAME_PREG_W 6

// Names beyond the architectural set live in the free list.
`define RENAME_FREE_DEPTH (`RENAME_PREGS - `RENAME_LREGS)

`endif

/* project.f */
+incdir+include
+incdir+verif
design/rename_pkg.sv
design/rename_if.sv
design/commit_if.sv
design/register_renaming_table.sv
design/rename_map.sv
design/free_list.sv
design/rename_stage_top.sv
verif/rename_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module rename_tb -f project.f -o rename_sim &&
./obj_dir/rename_sim || exit 1

/* verif/rename_model.svh */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

int spec_map [`RENAME_LREGS];	// Speculative map.
int comm_map [`RENAME_LREGS];	// Committed map.
int free_q [`RENAME_FREE_DEPTH];	// Circular list of free names.
int m_head;
int m_commit;
int m_tail;

function automatic void reset_model();
	for (int n = 0; n < `RENAME_LREGS; n++) begin
		spec_map[n] = n;	// Identity after init.
		comm_map[n] = n;
	end
	for (int k = 0; k < `RENAME_FREE_DEPTH; k++) begin
		free_q[k] = `RENAME_LREGS + k;
	end
	m_head = 0;
	m_commit = 0;
	m_tail = `RENAME_FREE_DEPTH;
endfunction

function automatic int new_name(int slot);
	return free_q[(m_head + slot) % `RENAME_FREE_DEPTH];
endfunction

function automatic bit lock_expected(bit stall_in, bit restart_in);
	return stall_in || restart_in || (m_tail - m_head < 2);
endfunction

// A lone instruction 1 takes the head slot.
function automatic int preg1_expected(bit v0);
	return v0 ? new_name(1) : new_name(0);
endfunction

function automatic int old1_expected(bit v0, int d0, bit v1, int d1);
	if (v0 && v1 && d0 == d1) begin
		return new_name(0);	// Displaces the name instruction 0 just took.
	end
	return spec_map[d1];
endfunction

function automatic int src1_expected(bit v0, int d0, int s1);
	if (v0 && d0 == s1) begin
		return new_name(0);
	end
	return spec_map[s1];
endfunction

function automatic void rename_group(bit v0, int d0, bit v1, int d1);
	int n0;
	int n1;
	n0 = new_name(0);
	n1 = preg1_expected(v0);
	if (v0) spec_map[d0] = n0;
	if (v1) spec_map[d1] = n1;	// Instruction 1 wins.
	m_head += int'(v0) + int'(v1);
endfunction

function automatic void commit_name(int lreg, int preg);
	comm_map[lreg] = preg;
	m_commit++;
endfunction

function automatic void release_name(int preg);
	free_q[m_tail % `RENAME_FREE_DEPTH] = preg;
	m_tail++;
endfunction

function automatic void rewind_map();
	spec_map = comm_map;
	m_head = m_commit;
endfunction

`endif

/* verif/rename_tb.sv */
`timescale 1ns/1ps
`include "rename_params.svh"

module rename_tb;
	localparam int max_cycles = 3000;	// Tests take about 2300 cycles.

	logic iCLOCK = 1'b0;
	logic inRESET;
	logic stall, restart, valid0, valid1, rename_lock;
	rename_pkg::lreg_t ldest0, ldest1, src0, src1;
	rename_pkg::preg_t preg0, preg1, old0, old1, src_preg0, src_preg1;
	logic [3:0] cand_valid;
	rename_pkg::lreg_t cand_lreg [4];
	rename_pkg::preg_t cand_preg [4];
	logic [1:0] rel_valid;
	rename_pkg::preg_t rel_preg [2];
	integer seed = 71;
	int cycles = 0;
	bit checking = 1'b0;
	int rob_lreg [$];	// Renamed but not yet committed.
	int rob_new [$];
	int rob_old [$];
	int pend_rel [$];	// Displaced names waiting for release.

	`include "rename_model.svh"

	rename_stage_top dut_i (
		.iCLOCK (iCLOCK), .inRESET (inRESET), .stall (stall),
		.valid0 (valid0), .ldest0 (ldest0), .valid1 (valid1), .ldest1 (ldest1),
		.src0 (src0), .src1 (src1), .preg0 (preg0), .preg1 (preg1),
		.old0 (old0), .old1 (old1), .src_preg0 (src_preg0), .src_preg1 (src_preg1),
		.rename_lock (rename_lock), .restart (restart),
		.cand0_valid (cand_valid[0]), .cand0_lreg (cand_lreg[0]), .cand0_preg (cand_preg[0]),
		.cand1_valid (cand_valid[1]), .cand1_lreg (cand_lreg[1]), .cand1_preg (cand_preg[1]),
		.cand2_valid (cand_valid[2]), .cand2_lreg (cand_lreg[2]), .cand2_preg (cand_preg[2]),
		.cand3_valid (cand_valid[3]), .cand3_lreg (cand_lreg[3]), .cand3_preg (cand_preg[3]),
		.release_valid0 (rel_valid[0]), .release_valid1 (rel_valid[1]),
		.release_preg0 (rel_preg[0]), .release_preg1 (rel_preg[1])
	);

	always #5 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Simulation failed");
			$fatal(1, "The run did not finish within %0d cycles", max_cycles);
		end
	end

	task automatic check_val(string name, int got, int exp);
		assert (got == exp) else begin
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Compare at the falling edge where inputs and outputs are settled
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge iCLOCK) begin
		bit lock_exp;
		if (checking) begin
			lock_exp = lock_expected(stall, restart);
			check_val("rename_lock", int'(rename_lock), int'(lock_exp));
			check_val("src_preg0", int'(src_preg0), spec_map[src0]);
			if (!lock_exp) begin
				if (valid0) begin
					check_val("preg0", int'(preg0), new_name(0));
					check_val("old0", int'(old0), spec_map[ldest0]);
				end
				if (valid1) begin
					check_val("preg1", int'(preg1), preg1_expected(valid0));
					check_val("old1", int'(old1),
						old1_expected(valid0, int'(ldest0), valid1, int'(ldest1)));
				end
				check_val("src_preg1", int'(src_preg1),
					src1_expected(valid0, int'(ldest0), int'(src1)));
			end else if (!(valid0 && ldest0 == src1)) begin
				check_val("src_preg1", int'(src_preg1), spec_map[src1]);	// No bypass.
			end
		end
	end

	// Drive one cycle and then follow the edge in the model.
	task automatic run_cycle(bit do_rename, int max_commit, int restart_odds, int stall_odds,
		int sweep);
		logic [31:0] r;
		bit restart_now;
		bit lock_now;
		int n_commit;
		int n0;
		int n1;
		r = $random(seed);
		restart_now = (restart_odds != 0) && ($unsigned($random(seed)) % restart_odds == 0);
		restart <= restart_now;
		stall <= (stall_odds != 0) && ($unsigned($random(seed)) % stall_odds == 0);
		valid0 <= do_rename && r[0];
		valid1 <= do_rename && r[1];
		ldest0 <= r[6:2];
		ldest1 <= (r[7] && r[8]) ? r[6:2] : r[13:9];	// Equal destinations now and then.
		src0 <= (sweep >= 0) ? rename_pkg::lreg_t'(sweep * 2) : r[18:14];
		src1 <= (sweep >= 0) ? rename_pkg::lreg_t'(sweep * 2 + 1) : (r[19] ? r[6:2] : r[24:20]);
		n_commit = restart_now ? 0 : $unsigned($random(seed)) % (max_commit + 1);
		if (n_commit > rob_lreg.size()) n_commit = rob_lreg.size();
		for (int i = 0; i < 4; i++) begin
			cand_valid[i] <= (i < n_commit);
			if (i < n_commit) begin
				cand_lreg[i] <= rename_pkg::lreg_t'(rob_lreg.pop_front());
				cand_preg[i] <= rename_pkg::preg_t'(rob_new.pop_front());
				pend_rel.push_back(rob_old.pop_front());
			end
		end
		for (int i = 0; i < 2; i++) begin
			rel_valid[i] <= (pend_rel.size() > 0);
			if (pend_rel.size() > 0) rel_preg[i] <= rename_pkg::preg_t'(pend_rel.pop_front());
		end
		@(posedge iCLOCK);
		lock_now = lock_expected(stall, restart);
		n0 = new_name(0);
		n1 = preg1_expected(valid0);
		if (restart) begin
			rewind_map();
			rob_lreg.delete();
			rob_new.delete();
			rob_old.delete();
		end else if (!lock_now) begin
			if (valid0) begin
				rob_lreg.push_back(int'(ldest0));
				rob_new.push_back(n0);
				rob_old.push_back(spec_map[ldest0]);
			end
			if (valid1) begin
				rob_lreg.push_back(int'(ldest1));
				rob_new.push_back(n1);
				rob_old.push_back(old1_expected(valid0, int'(ldest0), valid1, int'(ldest1)));
			end
			rename_group(valid0, int'(ldest0), valid1, int'(ldest1));
		end
		for (int i = 0; i < 4; i++) begin
			if (cand_valid[i]) commit_name(int'(cand_lreg[i]), int'(cand_preg[i]));
		end
		for (int i = 0; i < 2; i++) begin
			if (rel_valid[i]) release_name(int'(rel_preg[i]));
		end
	endtask

	initial begin
		inRESET <= 1'b0;
		stall <= 1'b0;
		restart <= 1'b0;
		valid0 <= 1'b0;
		valid1 <= 1'b0;
		ldest0 <= '0;
		ldest1 <= '0;
		src0 <= '0;
		src1 <= '0;
		cand_valid <= '0;
		rel_valid <= '0;
		for (int i = 0; i < 4; i++) begin
			cand_lreg[i] <= '0;
			cand_preg[i] <= '0;
		end
		rel_preg[0] <= '0;
		rel_preg[1] <= '0;
		repeat (5) @(posedge iCLOCK);
		inRESET <= 1'b1;
		@(negedge iCLOCK);
		check_val("rename_lock", int'(rename_lock), 1);	// Init cycle.
		@(posedge iCLOCK);
		reset_model();
		checking = 1'b1;
		for (int i = 0; i < 16; i++) run_cycle(1'b0, 0, 0, 0, i);	// Identity lookups.
		repeat (2000) run_cycle(1'b1, 4, 64, 8, -1);
		repeat (40) run_cycle(1'b1, 0, 0, 0, -1);	// Drain the free list.
		repeat (4) run_cycle(1'b0, 4, 0, 0, -1);
		run_cycle(1'b0, 0, 1, 0, -1);	// Forced restart.
		for (int i = 0; i < 16; i++) run_cycle(1'b0, 0, 0, 0, i);
		repeat (200) run_cycle(1'b1, 4, 64, 8, -1);
		$display("Simulation passed");
		$finish;
	end

endmodule
